// ==== Bender.yml ====
package:
  name: echo_router

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/echo_pkg.sv
      - source/echo_ingress_buf.sv
      - source/echo_port_map_regs.sv
      - source/echo_fwd_pipe.sv
      - source/echo_router_top.sv

  - target: test
    include_dirs:
      - source
    files:
      - sim/echo_router_tb.sv

// ==== build.f ====
+incdir+source
source/echo_pkg.sv
source/echo_ingress_buf.sv
source/echo_port_map_regs.sv
source/echo_fwd_pipe.sv
source/echo_router_top.sv
sim/echo_router_tb.sv

// ==== sim/echo_router_tb.sv ====
////////////////////////////////////////
// drives echo_router_top at negedge, samples at posedge
// map model tracks host writes, stimulus seeded with 22
////////////////////////////////////////

`include "echo_defs.svh"

module echo_router_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import echo_pkg::*;

    localparam int          DEPTH      = `ECHO_BUF_DEPTH;
    localparam int          NUM_PORTS  = `ECHO_NUM_PORTS;
    localparam int          WAIT_LIMIT = 1000;          // cycles per wait loop
    localparam logic [7:0]  MAP_BASE   = `ECHO_REG_MAP_BASE;
    localparam logic [31:0] CTRL_EN    = 32'h8000_0000; // ctrl_word_t enable
    localparam logic [31:0] CTRL_CLR   = 32'h4000_0000; // ctrl_word_t clear_drops

    logic       aclk       = 1'b0;
    logic       arst_n;
    logic       in_valid;
    beat_in_t   in_beat;
    logic       in_credit;
    logic       out_valid;
    beat_out_t  out_beat;
    logic       out_credit = 1'b0;
    reg_req_t   reg_req;
    reg_rsp_t   reg_rsp;
    logic       ecc_event;

    integer     seed = 22;
    int         errors, tests_run, tests_failed;
    int         beats_sent, credits_back, max_outstanding;  // upstream credit model
    int         cycle, out_count, ecc_count, exp_drops;
    logic       hold_credits = 1'b0;                        // downstream withholds
    beat_out_t  exp_q [$];                                  // expected output beats
    int         due_q [$];                                  // credit return cycles
    map_entry_t model_map [NUM_PORTS];

    echo_router_top dut0 (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_beat   (out_beat),
        .out_credit (out_credit),
        .reg_req    (reg_req),
        .reg_rsp    (reg_rsp),
        .ecc_event  (ecc_event)
    );

    always #10 aclk = ~aclk;    // 20 ns period

    ////////////////////////////////////////
    // reference and check helpers

    // egress port, bit 8 set when the packet must be dropped
    function automatic logic [8:0] expected_egress(input logic [7:0] port);
        map_entry_t e;
        if (port >= NUM_PORTS) return {1'b1, 8'h00};           // out of range
        e = model_map[port[3:0]];
        if (!e.valid) return {1'b1, 8'h00};
        if (^{e.valid, e.parity, e.egr_port}) return {1'b1, 8'h00};  // odd ones count
        return {1'b0, e.egr_port};
    endfunction

    function automatic logic [31:0] make_entry(input logic [7:0] egr, input logic valid,
                                               input logic good_parity);
        logic par;
        par = ^{valid, egr};                  // even over valid, parity, egr
        if (!good_parity) par = ~par;
        return {22'd0, valid, par, egr};
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors > errs_before) begin
            tests_failed++;
            $display("test %-14s %0d errors", name, errors - errs_before);
        end else begin
            $display("test %-14s ok", name);
        end
    endtask

    ////////////////////////////////////////
    // host port

    task automatic reg_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int t;
        reg_req.valid      = 1'b1;
        reg_req.write      = write;
        reg_req.addr       = addr;
        reg_req.wdata.word = wdata;
        @(negedge aclk);
        reg_req.valid = 1'b0;             // single cycle request
        t = 0;
        while (!reg_rsp.ack && t < WAIT_LIMIT) begin
            @(negedge aclk);
            t++;
        end
        if (!reg_rsp.ack) begin
            $display("timeout waiting for host register ack at address 0x%0h", addr);
            errors++;
        end
        rdata = reg_rsp.rdata;
        if (write && addr >= MAP_BASE && addr < MAP_BASE + NUM_PORTS) begin
            model_map[addr - MAP_BASE] = wdata[9:0];   // keep model in step
        end
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        reg_access(1'b1, addr, data, unused);
    endtask

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
        reg_access(1'b0, addr, 32'd0, data);
    endtask

    ////////////////////////////////////////
    // packet source and drain

    task automatic send_packet(input logic [7:0] port, input int nbeats);
        logic [8:0] res;
        beat_in_t   b;
        beat_out_t  e;
        int         t;
        res = expected_egress(port);      // first beat decides for the packet
        if (res[8]) exp_drops++;
        for (int i = 0; i < nbeats; i++) begin
            t = 0;
            in_valid = 1'b0;
            while (beats_sent - credits_back >= DEPTH && t < WAIT_LIMIT) begin
                @(negedge aclk);          // out of upstream credit
                t++;
            end
            if (t >= WAIT_LIMIT) begin
                $display("timeout waiting for upstream credit on port %0d", port);
                errors++;
                return;
            end
            b.data     = {$random(seed), $random(seed)};
            b.last     = (i == nbeats - 1);
            b.keep     = b.last ? 8'hff >> ($unsigned($random(seed)) % 8) : 8'hff;
            b.ing_port = port;
            in_valid   = 1'b1;
            in_beat    = b;
            beats_sent++;
            if (!res[8]) begin
                e.data     = b.data;
                e.keep     = b.keep;
                e.last     = b.last;
                e.egr_port = res[7:0];
                exp_q.push_back(e);
            end
            @(negedge aclk);
        end
        in_valid = 1'b0;
    endtask

    // all expected beats out and every pushed beat popped
    task automatic wait_idle();
        int t;
        t = 0;
        while ((exp_q.size() != 0 || beats_sent != credits_back) && t < WAIT_LIMIT) begin
            @(negedge aclk);
            t++;
        end
        if (t >= WAIT_LIMIT) begin
            $display("timeout waiting for the router to drain, %0d beats still expected",
                     exp_q.size());
            errors++;
        end
        repeat (3) @(negedge aclk);       // drop counter settles
    endtask

    ////////////////////////////////////////
    // monitors, compare, downstream model

    always @(posedge aclk) begin
        if (arst_n) begin
            if (in_credit) credits_back++;
            if (beats_sent - credits_back > max_outstanding) begin
                max_outstanding = beats_sent - credits_back;
            end
            if (ecc_event) ecc_count++;
        end
    end

    always @(posedge aclk) begin : compare_out
        beat_out_t e;
        if (arst_n && out_valid) begin
            out_count++;
            if (exp_q.size() == 0) begin
                $display("output beat arrived with no packet expected, egress 0x%0h",
                         out_beat.egr_port);
                errors++;
            end else begin
                e = exp_q.pop_front();    // in order, nothing skipped
                check_value("out_beat.data", out_beat.data, e.data);
                check_value("out_beat.keep", out_beat.keep, e.keep);
                check_value("out_beat.last", out_beat.last, e.last);
                check_value("out_beat.egr_port", out_beat.egr_port, e.egr_port);
            end
        end
    end

    always @(posedge aclk) begin
        if (arst_n && out_valid) begin
            due_q.push_back(cycle + int'($unsigned($random(seed)) % 4));  // 0..3 late
        end
        cycle++;
    end

    always @(negedge aclk) begin : credit_return
        out_credit = 1'b0;
        if (!hold_credits && due_q.size() != 0 && due_q[0] <= cycle) begin
            out_credit = 1'b1;
            void'(due_q.pop_front());
        end
    end

    initial begin
        for (int c = 0; c < 100000; c++) @(posedge aclk);
        $display("simulation ran past its cycle budget, run stopped");
        $display("Test failures found");
        $finish;
    end

    ////////////////////////////////////////
    // test sequence

    initial begin : main
        logic [31:0] rd;
        int          err0;
        int          n0;
        arst_n  = 1'b0;
        in_valid = 1'b0;
        in_beat = '0;
        reg_req = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            model_map[p].valid    = 1'b1;                 // identity at reset
            model_map[p].egr_port = p[7:0];
            model_map[p].parity   = ^{1'b1, p[7:0]};
        end
        repeat (4) @(negedge aclk);
        arst_n = 1'b1;
        @(negedge aclk);

        err0 = errors;                                    // reset state
        check_value("in_credit", in_credit, 0);
        check_value("out_valid", out_valid, 0);
        check_value("ecc_event", ecc_event, 0);
        check_value("reg_rsp.ack", reg_rsp.ack, 0);
        reg_read(`ECHO_REG_CTRL, rd);
        check_value("ctrl", rd, 0);
        reg_read(`ECHO_REG_DROPS, rd);
        check_value("drops", rd, 0);
        reg_read(MAP_BASE + 8'd3, rd);
        check_value("map[3]", rd, make_entry(8'd3, 1'b1, 1'b1));
        end_test("reset", err0);

        err0 = errors;                                    // identity echo
        reg_write(`ECHO_REG_CTRL, CTRL_EN);
        send_packet(8'd0, 1);
        send_packet(8'd3, 2);
        send_packet(8'd7, 3);
        send_packet(8'd12, 4);
        send_packet(8'd15, 5);
        wait_idle();
        end_test("identity", err0);

        err0 = errors;                                    // remap
        reg_write(MAP_BASE + 8'd2, make_entry(8'd9, 1'b1, 1'b1));
        reg_write(MAP_BASE + 8'd5, make_entry(8'd12, 1'b1, 1'b1));
        reg_read(MAP_BASE + 8'd2, rd);
        check_value("map[2]", rd, make_entry(8'd9, 1'b1, 1'b1));
        reg_read(MAP_BASE + 8'd5, rd);
        check_value("map[5]", rd, make_entry(8'd12, 1'b1, 1'b1));
        send_packet(8'd2, 4);
        send_packet(8'd5, 2);
        send_packet(8'd2, 1);
        wait_idle();
        end_test("remap", err0);

        err0 = errors;                                    // invalid entry and port 20
        reg_write(`ECHO_REG_CTRL, CTRL_EN | CTRL_CLR);
        exp_drops = 0;
        reg_write(MAP_BASE + 8'd4, make_entry(8'd4, 1'b0, 1'b1));
        send_packet(8'd4, 3);
        send_packet(8'd1, 2);
        send_packet(8'd20, 2);
        wait_idle();
        reg_read(`ECHO_REG_DROPS, rd);
        check_value("drops", rd, exp_drops);
        reg_write(`ECHO_REG_CTRL, CTRL_EN | CTRL_CLR);
        exp_drops = 0;
        reg_read(`ECHO_REG_DROPS, rd);
        check_value("drops after clear", rd, 0);
        end_test("drops", err0);

        err0 = errors;                                    // planted parity error
        n0 = ecc_count;
        reg_write(MAP_BASE + 8'd6, make_entry(8'd6, 1'b1, 1'b0));
        send_packet(8'd6, 3);
        send_packet(8'd0, 2);
        wait_idle();
        check_value("ecc_event pulses", ecc_count - n0, 1);
        reg_read(`ECHO_REG_DROPS, rd);
        check_value("drops", rd, exp_drops);
        end_test("parity", err0);

        err0 = errors;                                    // back-pressure
        max_outstanding = 0;
        fork
            begin
                for (int i = 0; i < 6; i++) begin
                    send_packet(i * 2 + 1, 3 + int'($unsigned($random(seed)) % 3));
                end
            end
            begin
                @(posedge aclk) hold_credits = 1'b1;
                repeat (60) @(posedge aclk);
                hold_credits = 1'b0;
                repeat (8) @(posedge aclk);
                hold_credits = 1'b1;
                repeat (60) @(posedge aclk);
                hold_credits = 1'b0;
            end
        join
        wait_idle();
        check_value("max_outstanding", max_outstanding, DEPTH);  // buffer filled, not overrun
        end_test("backpressure", err0);

        err0 = errors;                                    // enable low holds traffic
        reg_write(`ECHO_REG_CTRL, 32'd0);
        n0 = out_count;
        send_packet(8'd8, 3);
        send_packet(8'd9, 4);
        repeat (30) @(negedge aclk);
        check_value("beats out while disabled", out_count, n0);
        reg_write(`ECHO_REG_CTRL, CTRL_EN);
        wait_idle();
        end_test("enable", err0);

        $display("summary: %0d tests, %0d failed, %0d check errors, %0d beats out",
                 tests_run, tests_failed, errors, out_count);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== source/echo_defs.svh ====
////////////////////////////////////////
// ECHO_BUF_DEPTH and ECHO_NUM_PORTS must be powers of two
// register addresses are word addresses on the host port
////////////////////////////////////////

`ifndef ECHO_DEFS_SVH
`define ECHO_DEFS_SVH

////////////////////////////////////////
// packet beat
`define ECHO_DATA_W       64      // beat payload bits
`define ECHO_KEEP_W       8       // one keep bit per byte
`define ECHO_PORT_W       8       // ingress / egress port id

////////////////////////////////////////
// sizing
`define ECHO_NUM_PORTS    16      // port map entries, ids 0..15
`define ECHO_BUF_DEPTH    8       // ingress fifo slots = upstream credits
`define ECHO_TX_CREDITS   4       // initial credits toward downstream

////////////////////////////////////////
// host register map
`define ECHO_REG_W        32      // host data word
`define ECHO_ADDR_W       8       // host address
`define ECHO_REG_CTRL     8'h00   // enable, clear_drops
`define ECHO_REG_DROPS    8'h01   // dropped packet count, read only
`define ECHO_REG_MAP_BASE 8'h10   // map entry p at base + p

`endif

// ==== source/echo_fwd_pipe.sv ====
////////////////////////////////////////
// downstream returns one out_credit per beat, never more than it got
// two stages, pop to out_valid in two cycles, no stall inside
////////////////////////////////////////

`include "echo_defs.svh"

module echo_fwd_pipe (
    input  logic                  aclk,
    input  logic                  arst_n,
    input  logic                  buf_valid,
    input  echo_pkg::beat_in_t    buf_beat,
    output logic                  buf_pop,
    input  logic                  enable,
    output echo_pkg::lookup_req_t lookup_req,
    input  echo_pkg::map_entry_t  lookup_entry,
    output logic                  drop_pulse,
    output logic                  ecc_event,
    output logic                  out_valid,
    output echo_pkg::beat_out_t   out_beat,
    input  logic                  out_credit
);

    import echo_pkg::*;

    localparam int TX_CREDITS = `ECHO_TX_CREDITS;
    localparam int CRED_W     = $clog2(TX_CREDITS + 1);

    logic                    sop_q;       // next popped beat starts a packet
    logic                    drop_q;      // per packet drop decision
    logic [`ECHO_PORT_W-1:0] egr_q;       // per packet egress port
    logic                    parity_err;
    logic                    first_drop;
    logic                    cur_drop;
    logic [`ECHO_PORT_W-1:0] cur_egr;
    logic                    spend;       // popped beat that goes out
    logic [CRED_W-1:0]       credits;     // free downstream credits
    logic [CRED_W-1:0]       in_flight;   // sent, not yet credited back
    logic                    s1_valid;
    beat_out_t               s1_beat;

    ////////////////////////////////////////
    // lookup and pop decision

    assign lookup_req.port = buf_beat.ing_port;
    assign parity_err      = lookup_entry.parity
                             != map_parity(lookup_entry.egr_port, lookup_entry.valid);
    assign first_drop      = parity_err | ~lookup_entry.valid;
    assign cur_drop        = sop_q ? first_drop : drop_q;             // first beat decides
    assign cur_egr         = sop_q ? lookup_entry.egr_port : egr_q;
    assign buf_pop         = buf_valid & enable & (cur_drop | (credits != '0));
    assign spend           = buf_pop & ~cur_drop;                     // drops cost no credit

    ////////////////////////////////////////
    // packet tracking

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            sop_q      <= 1'b1;
            drop_q     <= 1'b0;
            egr_q      <= '0;
            drop_pulse <= 1'b0;
            ecc_event  <= 1'b0;
        end else begin
            drop_pulse <= buf_pop & sop_q & first_drop;   // once per packet
            ecc_event  <= buf_pop & sop_q & parity_err;
            if (buf_pop) begin
                sop_q <= buf_beat.last;
                if (sop_q) begin
                    drop_q <= first_drop;
                    egr_q  <= lookup_entry.egr_port;
                end
            end
        end
    end

    ////////////////////////////////////////
    // credits

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            credits   <= CRED_W'(TX_CREDITS);
            in_flight <= '0;
        end else begin
            credits   <= credits - CRED_W'(spend) + CRED_W'(out_credit);
            in_flight <= in_flight + CRED_W'(out_valid) - CRED_W'(out_credit);
        end
    end

    ////////////////////////////////////////
    // stage valids and payload

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= spend;
            out_valid <= s1_valid;        // credit already reserved
        end
    end

    always_ff @(posedge aclk) begin
        if (spend) begin
            s1_beat.data     <= buf_beat.data;
            s1_beat.keep     <= buf_beat.keep;
            s1_beat.last     <= buf_beat.last;
            s1_beat.egr_port <= cur_egr;
        end
        if (s1_valid) begin
            out_beat <= s1_beat;
        end
    end

    ////////////////////////////////////////
    // credit checks

    // every credit is free, held by a stage, or out at downstream
    a_credit_balance: assert property (
        @(posedge aclk) disable iff (!arst_n)
        (int'(credits) + int'(s1_valid) + int'(out_valid) + int'(in_flight)) == TX_CREDITS
    ) else $error("downstream credit count lost balance, underflow or excess credit");

    a_out_has_credit: assert property (
        @(posedge aclk) disable iff (!arst_n)
        out_valid |-> (in_flight < CRED_W'(TX_CREDITS))
    ) else $error("out_valid raised with all downstream credits outstanding");

endmodule

// ==== source/echo_ingress_buf.sv ====
////////////////////////////////////////
// sender may push only while holding a credit, ECHO_BUF_DEPTH at reset
// head beat is valid one cycle after its push
////////////////////////////////////////

`include "echo_defs.svh"

module echo_ingress_buf (
    input  logic               aclk,
    input  logic               arst_n,
    input  logic               in_valid,
    input  echo_pkg::beat_in_t in_beat,
    output logic               in_credit,
    output logic               buf_valid,
    output echo_pkg::beat_in_t buf_beat,
    input  logic               buf_pop
);

    import echo_pkg::*;

    localparam int DEPTH = `ECHO_BUF_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    beat_in_t         mem [DEPTH];  // beat storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;        // occupancy
    logic             full;
    logic             push;
    logic             pop;

    ////////////////////////////////////////
    // status and head

    assign full      = (count == CNT_W'(DEPTH));
    assign buf_valid = (count != '0);       // show-ahead
    assign buf_beat  = mem[rd_ptr];
    assign push      = in_valid & ~full;    // guarded, see assertion
    assign pop       = buf_pop & buf_valid;

    ////////////////////////////////////////
    // storage

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    ////////////////////////////////////////
    // pointers, count, credit return

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps at DEPTH
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
            in_credit <= pop;               // one slot back per pop
        end
    end

    ////////////////////////////////////////
    // protocol checks

    // upstream credit accounting must keep pushes within the free slots
    a_no_push_full: assert property (
        @(posedge aclk) disable iff (!arst_n)
        in_valid |-> !full
    ) else $error("ingress push while buffer full, upstream overran its credits");

    // pipeline must only pop a beat it can see
    a_no_pop_empty: assert property (
        @(posedge aclk) disable iff (!arst_n)
        buf_pop |-> buf_valid
    ) else $error("pop from empty ingress buffer");

endmodule

// ==== source/echo_pkg.sv ====
////////////////////////////////////////
// ingress port rides on every beat but only the first beat's is used
// map parity is even over {valid, egr_port}
////////////////////////////////////////

`include "echo_defs.svh"

package echo_pkg;

    ////////////////////////////////////////
    // packet beats

    typedef struct packed {
        logic [`ECHO_DATA_W-1:0] data;     // payload
        logic [`ECHO_KEEP_W-1:0] keep;     // byte enables
        logic                    last;     // end of packet
        logic [`ECHO_PORT_W-1:0] ing_port; // sideband ingress id
    } beat_in_t;

    typedef struct packed {
        logic [`ECHO_DATA_W-1:0] data;
        logic [`ECHO_KEEP_W-1:0] keep;
        logic                    last;
        logic [`ECHO_PORT_W-1:0] egr_port; // resolved egress id
    } beat_out_t;

    ////////////////////////////////////////
    // port map table

    typedef struct packed {
        logic                    valid;    // entry in use
        logic                    parity;   // stored as written by host
        logic [`ECHO_PORT_W-1:0] egr_port;
    } map_entry_t;

    typedef struct packed {
        logic [`ECHO_PORT_W-1:0] port;     // index into the table
    } lookup_req_t;

    function automatic logic map_parity(logic [`ECHO_PORT_W-1:0] egr_port, logic valid);
        return ^{valid, egr_port};         // makes total ones count even
    endfunction

    ////////////////////////////////////////
    // host register port

    typedef struct packed {
        logic        enable;               // forwarding on
        logic        clear_drops;          // self clearing
        logic [29:0] reserved;
    } ctrl_word_t;

    typedef struct packed {
        logic [`ECHO_REG_W-$bits(map_entry_t)-1:0] reserved;
        map_entry_t                                entry;
    } map_word_t;

    typedef union packed {
        logic [`ECHO_REG_W-1:0] word;      // raw view
        ctrl_word_t             ctrl;      // at ECHO_REG_CTRL
        map_word_t              map;       // at map base + p
    } reg_wdata_u;

    typedef struct packed {
        logic                    valid;
        logic                    write;    // 1 write, 0 read
        logic [`ECHO_ADDR_W-1:0] addr;
        reg_wdata_u              wdata;
    } reg_req_t;

    typedef struct packed {
        logic                   ack;       // one cycle after valid
        logic [`ECHO_REG_W-1:0] rdata;     // zero for writes and holes
    } reg_rsp_t;

endpackage

// ==== source/echo_port_map_regs.sv ====
////////////////////////////////////////
// map entries keep the parity bit exactly as written
// reads of unmapped addresses and all writes return rdata 0
////////////////////////////////////////

`include "echo_defs.svh"

module echo_port_map_regs (
    input  logic                  aclk,
    input  logic                  arst_n,
    input  echo_pkg::reg_req_t    reg_req,
    output echo_pkg::reg_rsp_t    reg_rsp,
    input  echo_pkg::lookup_req_t lookup_req,
    output echo_pkg::map_entry_t  lookup_entry,
    input  logic                  drop_pulse,
    output logic                  enable
);

    import echo_pkg::*;

    localparam int NUM_PORTS = `ECHO_NUM_PORTS;
    localparam int IDX_W     = $clog2(NUM_PORTS);
    localparam int PORT_W    = `ECHO_PORT_W;
    localparam int ADDR_W    = `ECHO_ADDR_W;

    localparam logic [ADDR_W-1:0] MAP_END = `ECHO_REG_MAP_BASE + ADDR_W'(NUM_PORTS);

    ctrl_word_t             ctrl_q;               // only enable is stored
    map_entry_t             map_q [NUM_PORTS];    // port map table
    logic [`ECHO_REG_W-1:0] drop_cnt;
    logic                   wr_en;
    logic                   map_hit;              // addr inside the table window
    logic [IDX_W-1:0]       map_idx;
    logic                   clear_drops;
    reg_wdata_u             rd_word;              // read data assembly

    ////////////////////////////////////////
    // address decode

    assign wr_en       = reg_req.valid & reg_req.write;
    assign map_hit     = (reg_req.addr >= `ECHO_REG_MAP_BASE) && (reg_req.addr < MAP_END);
    assign map_idx     = IDX_W'(reg_req.addr - `ECHO_REG_MAP_BASE);
    assign clear_drops = wr_en && (reg_req.addr == `ECHO_REG_CTRL)
                         && reg_req.wdata.ctrl.clear_drops;
    assign enable      = ctrl_q.enable;

    ////////////////////////////////////////
    // control and drop counter

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_q   <= '0;                       // forwarding off
            drop_cnt <= '0;
        end else begin
            if (wr_en && (reg_req.addr == `ECHO_REG_CTRL)) begin
                ctrl_q.enable <= reg_req.wdata.ctrl.enable;
            end
            if (clear_drops) begin
                drop_cnt <= '0;                   // clear wins over a drop
            end else if (drop_pulse) begin
                drop_cnt <= drop_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // port map table

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                map_q[p].valid    <= 1'b1;        // identity map
                map_q[p].egr_port <= PORT_W'(p);
                map_q[p].parity   <= map_parity(PORT_W'(p), 1'b1);
            end
        end else if (wr_en && map_hit) begin
            map_q[map_idx] <= reg_req.wdata.map.entry;   // bad parity allowed
        end
    end

    // out of range ports see an invalid entry
    always_comb begin
        lookup_entry = '0;
        if (lookup_req.port < PORT_W'(NUM_PORTS)) begin
            lookup_entry = map_q[lookup_req.port[IDX_W-1:0]];
        end
    end

    ////////////////////////////////////////
    // host read path

    always_comb begin
        rd_word.word = '0;                        // holes read zero
        if (reg_req.addr == `ECHO_REG_CTRL) begin
            rd_word.ctrl = ctrl_q;
        end else if (reg_req.addr == `ECHO_REG_DROPS) begin
            rd_word.word = drop_cnt;
        end else if (map_hit) begin
            rd_word.map.entry = map_q[map_idx];
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            reg_rsp <= '0;
        end else begin
            reg_rsp.ack   <= reg_req.valid;       // single cycle ack
            reg_rsp.rdata <= (reg_req.valid && !reg_req.write) ? rd_word.word : '0;
        end
    end

endmodule

// ==== source/echo_router_top.sv ====
////////////////////////////////////////
// single clock aclk, host port replaces AXI4-Lite
// nothing forwards until the host sets enable
////////////////////////////////////////

`include "echo_defs.svh"

module echo_router_top (
    input  logic               aclk,
    input  logic               arst_n,
    input  logic               in_valid,
    input  echo_pkg::beat_in_t in_beat,
    output logic               in_credit,
    output logic               out_valid,
    output echo_pkg::beat_out_t out_beat,
    input  logic               out_credit,
    input  echo_pkg::reg_req_t reg_req,
    output echo_pkg::reg_rsp_t reg_rsp,
    output logic               ecc_event
);

    import echo_pkg::*;

    logic        buf_valid;     // fifo head present
    beat_in_t    buf_beat;
    logic        buf_pop;
    lookup_req_t lookup_req;    // comb lookup into table
    map_entry_t  lookup_entry;
    logic        drop_pulse;
    logic        enable;

    ////////////////////////////////////////
    // ingress buffer

    echo_ingress_buf u_buf (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .in_credit (in_credit),
        .buf_valid (buf_valid),
        .buf_beat  (buf_beat),
        .buf_pop   (buf_pop)
    );

    ////////////////////////////////////////
    // forwarding pipeline and its table

    echo_fwd_pipe u_pipe (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .buf_valid    (buf_valid),
        .buf_beat     (buf_beat),
        .buf_pop      (buf_pop),
        .enable       (enable),
        .lookup_req   (lookup_req),
        .lookup_entry (lookup_entry),
        .drop_pulse   (drop_pulse),
        .ecc_event    (ecc_event),
        .out_valid    (out_valid),
        .out_beat     (out_beat),
        .out_credit   (out_credit)
    );

    echo_port_map_regs u_regs (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .reg_req      (reg_req),
        .reg_rsp      (reg_rsp),
        .lookup_req   (lookup_req),
        .lookup_entry (lookup_entry),
        .drop_pulse   (drop_pulse),
        .enable       (enable)
    );

endmodule
